/* hdl/fetch_pkg.sv */
// Fetch stage shared definitions
`default_nettype none

package fetch_pkg;

    // Native data word width.
    localparam int xlen = 32;

    // Halfword-granular program counter.
    typedef logic [xlen-1:1] pc_t;

    // Word-granular bus address.
    typedef logic [xlen-1:2] waddr_t;

    // Raw instruction word as returned by the bus.
    typedef logic [xlen-1:0] word_t;

    // Permission tag stored with each buffered word.
    typedef struct packed {
        // Check was run for machine mode.
        logic m_mode;
        // Execution allowed.
        logic x;
    } perm_t;

    // Privilege level.
    typedef logic [1:0] priv_t;

    localparam priv_t priv_user    = 2'd0;
    localparam priv_t priv_machine = 2'd3;

    // Trap cause code.
    typedef logic [3:0] cause_t;

    // Instruction access fault.
    localparam cause_t cause_iaccess = 4'd1;

endpackage

`default_nettype wire

/* hdl/onehot_mux.sv */
// One-hot payload selector
`timescale 1ns/10ps
`default_nettype none

module onehot_mux #(
    // Number of entries.
    parameter int n = 2,
    // Entry payload type.
    parameter type payload_t = logic
) (
    input  wire logic [n-1:0] sel,
    input  wire payload_t     entries [n],
    output payload_t          y
);

    // Flat width of one payload.
    localparam int w = $bits(payload_t);

    logic [w-1:0] acc;

    // OR of all selected entries.
    // With a one-hot mask this is just the picked entry.
    always_comb begin
        acc = '0;
        for (int i = 0; i < n; i++) begin
            if (sel[i]) begin
                acc = acc | w'(entries[i]);
            end
        end
    end

    assign y = payload_t'(acc);

endmodule

`default_nettype wire

/* hdl/fetch_buffer_lookup.sv */
// Fetch buffer address lookup
`timescale 1ns/10ps
`default_nettype none

module fetch_buffer_lookup import fetch_pkg::*; #(
    // Fetch buffer depth, at least 2.
    parameter int depth = 4
) (
    input  wire logic   m_mode,
    input  wire word_t  buf_data  [depth],
    input  wire waddr_t buf_addr  [depth],
    input  wire logic   buf_valid [depth],
    input  wire perm_t  buf_perm  [depth],
    input  wire waddr_t addr,
    output logic        hit,
    output word_t       data,
    output perm_t       perm
);

    // Raw matches per entry.
    logic [depth-1:0] match;
    // Youngest match only.
    logic [depth-1:0] mask;

    // Entry 0 is the live bus answer.
    // Its tag was taken for the mode of the request, so no mode check.
    assign match[0] = buf_valid[0] && buf_addr[0] == addr;
    assign mask[0]  = match[0];

    // Older entries must have been checked for the current mode.
    for (genvar i = 1; i < depth; i++) begin : g_match
        assign match[i] = buf_valid[i] && buf_addr[i] == addr
                          && buf_perm[i].m_mode == m_mode;
        // Lower index is younger and wins.
        assign mask[i]  = match[i] && match[i-1:0] == '0;
    end

    assign hit = |match;

    // Word of the winning entry.
    onehot_mux #(
        .n         (depth),
        .payload_t (word_t)
    ) data_mux (
        .sel     (mask),
        .entries (buf_data),
        .y       (data)
    );

    // Permission tag of the winning entry.
    onehot_mux #(
        .n         (depth),
        .payload_t (perm_t)
    ) perm_mux (
        .sel     (mask),
        .entries (buf_perm),
        .y       (perm)
    );

endmodule

`default_nettype wire

/* hdl/fetch_stage.sv */
// Instruction fetch stage
`timescale 1ns/10ps
`default_nettype none

module fetch_stage import fetch_pkg::*; #(
    // Reset PC.
    parameter logic [31:0] entrypoint = 32'h0000_0000,
    // Fetch buffer depth, at least 2.
    parameter int          buf_depth  = 4
) (
    input  wire logic   clk,
    input  wire logic   rst,
    input  wire logic   clear,
    input  wire logic   fence_i,
    input  wire priv_t  cur_priv,
    input  wire logic   stall,
    input  wire logic   exception,
    input  wire pc_t    tvec,
    input  wire logic   branch_correct,
    input  wire pc_t    branch_alt,
    input  wire logic   branch_predict,
    input  wire pc_t    branch_target,
    output pc_t         next_pc,
    output logic        mem_re,
    output waddr_t      mem_addr,
    input  wire word_t  mem_rdata,
    input  wire logic   mem_ready,
    input  wire logic   perm_x,
    output logic        q_valid,
    output pc_t         q_pc,
    output word_t       q_insn,
    output logic        q_trap,
    output cause_t      q_cause
);

    // Registered PC.
    pc_t  pc;
    // Address of the instruction looked up this cycle.
    pc_t  fetch_addr;
    // Following halfword and following instruction.
    pc_t  next_hw;
    pc_t  next_addr;
    logic cur_m;

    // Tags of the request issued last cycle.
    waddr_t addr0_q;
    perm_t  perm0_q;

    // Older buffer entries, index 0 here is buffer entry 1.
    word_t  sh_data  [buf_depth-1];
    waddr_t sh_addr  [buf_depth-1];
    logic   sh_valid [buf_depth-1];
    perm_t  sh_perm  [buf_depth-1];

    // Whole buffer as seen by the lookups.
    word_t  buf_data  [buf_depth];
    waddr_t buf_addr  [buf_depth];
    logic   buf_valid [buf_depth];
    perm_t  buf_perm  [buf_depth];

    logic  hit_lo;
    logic  hit_hi;
    word_t data_lo;
    word_t data_hi;
    perm_t perm_lo;
    perm_t perm_hi;

    word_t insn;
    logic  is_32;
    logic  insn_valid;
    logic  q_fire;
    logic  denied;

    assign cur_m   = cur_priv == priv_machine;
    assign next_pc = pc;

    // Fetch address, highest priority first.
    always_comb begin
        if (rst) begin
            fetch_addr = entrypoint[31:1];
        end else if (stall) begin
            fetch_addr = pc;
        end else if (exception) begin
            // Vector is word aligned.
            fetch_addr = {tvec[31:2], 1'b0};
        end else if (branch_correct) begin
            fetch_addr = branch_alt;
        end else if (branch_predict) begin
            fetch_addr = branch_target;
        end else begin
            fetch_addr = pc;
        end
    end

    assign next_hw = fetch_addr + pc_t'(1);

    // Entry 0 is the bus answer, the rest are the shift registers.
    always_comb begin
        buf_data[0]  = mem_rdata;
        buf_addr[0]  = addr0_q;
        buf_valid[0] = mem_ready;
        buf_perm[0]  = perm0_q;
        for (int i = 1; i < buf_depth; i++) begin
            buf_data[i]  = sh_data[i-1];
            buf_addr[i]  = sh_addr[i-1];
            buf_valid[i] = sh_valid[i-1];
            buf_perm[i]  = sh_perm[i-1];
        end
    end

    // Tag the outgoing request.
    // The answer comes back next cycle as entry 0.
    always_ff @(posedge clk) begin
        addr0_q        <= mem_addr;
        perm0_q.m_mode <= cur_m;
        perm0_q.x      <= perm_x;
    end

    // Valid bits shift only on answers.
    always_ff @(posedge clk) begin
        if (rst || fence_i) begin
            for (int i = 0; i < buf_depth - 1; i++) begin
                sh_valid[i] <= 1'b0;
            end
        end else if (mem_ready) begin
            for (int i = 0; i < buf_depth - 1; i++) begin
                sh_valid[i] <= buf_valid[i];
            end
        end
    end

    // Payload follows the valid bits.
    always_ff @(posedge clk) begin
        if (mem_ready) begin
            for (int i = 0; i < buf_depth - 1; i++) begin
                sh_data[i] <= buf_data[i];
                sh_addr[i] <= buf_addr[i];
                sh_perm[i] <= buf_perm[i];
            end
        end
    end

    // Word holding the first halfword.
    fetch_buffer_lookup #(
        .depth (buf_depth)
    ) lookup_lo (
        .m_mode    (cur_m),
        .buf_data  (buf_data),
        .buf_addr  (buf_addr),
        .buf_valid (buf_valid),
        .buf_perm  (buf_perm),
        .addr      (fetch_addr[31:2]),
        .hit       (hit_lo),
        .data      (data_lo),
        .perm      (perm_lo)
    );

    // Word holding the second halfword.
    fetch_buffer_lookup #(
        .depth (buf_depth)
    ) lookup_hi (
        .m_mode    (cur_m),
        .buf_data  (buf_data),
        .buf_addr  (buf_addr),
        .buf_valid (buf_valid),
        .buf_perm  (buf_perm),
        .addr      (next_hw[31:2]),
        .hit       (hit_hi),
        .data      (data_hi),
        .perm      (perm_hi)
    );

    // Instruction assembly from two halfwords.
    assign insn[15:0]  = fetch_addr[1] ? data_lo[31:16] : data_lo[15:0];
    assign insn[31:16] = next_hw[1] ? data_hi[31:16] : data_hi[15:0];
    assign is_32       = insn[1:0] == 2'b11;
    assign insn_valid  = hit_lo && (!is_32 || hit_hi);
    assign next_addr   = fetch_addr + (is_32 ? pc_t'(2) : pc_t'(1));

    // Bus request.
    always_comb begin
        mem_re   = 1'b1;
        mem_addr = fetch_addr[31:2];
        if (rst || fence_i) begin
            mem_re = 1'b0;
        end else if (!hit_lo) begin
            // Low half missing.
            mem_addr = fetch_addr[31:2];
        end else if (is_32 && !hit_hi) begin
            // High half of a straddling instruction missing.
            mem_addr = next_hw[31:2];
        end else begin
            // Prefetch past the newest request.
            mem_addr = addr0_q + waddr_t'(1);
        end
    end

    // Output, trap when either used half lacks execute permission.
    assign q_fire = insn_valid && !clear && !fence_i;
    assign denied = !perm_lo.x || (is_32 && !perm_hi.x);
    assign q_pc   = fetch_addr;
    assign q_insn = insn;

    always_comb begin
        q_valid = 1'b0;
        q_trap  = 1'b0;
        q_cause = '0;
        if (q_fire) begin
            if (denied) begin
                q_trap  = 1'b1;
                q_cause = cause_iaccess;
            end else begin
                q_valid = 1'b1;
            end
        end
    end

    // PC update, held under stall.
    // Suppressed outputs keep the PC so nothing is skipped.
    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= entrypoint[31:1];
        end else if (!stall) begin
            pc <= q_fire ? next_addr : fetch_addr;
        end
    end

endmodule

`default_nettype wire

/* hdl/exec_pmp.sv */
// Fixed execute permission checker
`timescale 1ns/10ps
`default_nettype none

module exec_pmp import fetch_pkg::*; #(
    // Machine mode region, base inclusive, limit exclusive.
    parameter logic [31:0] m_base  = 32'h0000_0000,
    parameter logic [31:0] m_limit = 32'h0000_0800,
    // User mode region, same convention.
    parameter logic [31:0] u_base  = 32'h0000_0400,
    parameter logic [31:0] u_limit = 32'h0000_1000
) (
    input  wire waddr_t addr,
    input  wire priv_t  cur_priv,
    output logic        perm_x
);

    // Byte address of the requested word.
    logic [31:0] byte_addr;
    logic        in_m;
    logic        in_u;

    assign byte_addr = {addr, 2'b00};

    // Region hits.
    assign in_m = byte_addr >= m_base && byte_addr < m_limit;
    assign in_u = byte_addr >= u_base && byte_addr < u_limit;

    // Machine mode uses its own region, any other level the user one.
    assign perm_x = cur_priv == priv_machine ? in_m : in_u;

endmodule

`default_nettype wire

/* hdl/fetch_top.sv */
// Fetch stage top level
`timescale 1ns/10ps
`default_nettype none

module fetch_top import fetch_pkg::*; #(
    // Reset PC.
    parameter logic [31:0] entrypoint = 32'h0000_0000,
    // Fetch buffer depth.
    parameter int          buf_depth  = 4,
    // Execute regions.
    parameter logic [31:0] m_base     = 32'h0000_0000,
    parameter logic [31:0] m_limit    = 32'h0000_0800,
    parameter logic [31:0] u_base     = 32'h0000_0400,
    parameter logic [31:0] u_limit    = 32'h0000_1000
) (
    input  wire logic   clk,
    input  wire logic   rst,
    input  wire logic   clear,
    input  wire logic   fence_i,
    input  wire priv_t  cur_priv,
    input  wire logic   stall,
    input  wire logic   exception,
    input  wire pc_t    tvec,
    input  wire logic   branch_correct,
    input  wire pc_t    branch_alt,
    input  wire logic   branch_predict,
    input  wire pc_t    branch_target,
    output pc_t         next_pc,
    output logic        mem_re,
    output waddr_t      mem_addr,
    input  wire word_t  mem_rdata,
    input  wire logic   mem_ready,
    output logic        q_valid,
    output pc_t         q_pc,
    output word_t       q_insn,
    output logic        q_trap,
    output cause_t      q_cause
);

    // Execute permission for the current bus address.
    logic perm_x;

    fetch_stage #(
        .entrypoint (entrypoint),
        .buf_depth  (buf_depth)
    ) fetch_stage_i (
        .clk            (clk),
        .rst            (rst),
        .clear          (clear),
        .fence_i        (fence_i),
        .cur_priv       (cur_priv),
        .stall          (stall),
        .exception      (exception),
        .tvec           (tvec),
        .branch_correct (branch_correct),
        .branch_alt     (branch_alt),
        .branch_predict (branch_predict),
        .branch_target  (branch_target),
        .next_pc        (next_pc),
        .mem_re         (mem_re),
        .mem_addr       (mem_addr),
        .mem_rdata      (mem_rdata),
        .mem_ready      (mem_ready),
        .perm_x         (perm_x),
        .q_valid        (q_valid),
        .q_pc           (q_pc),
        .q_insn         (q_insn),
        .q_trap         (q_trap),
        .q_cause        (q_cause)
    );

    // Checked on the request, tagged onto the answer.
    exec_pmp #(
        .m_base  (m_base),
        .m_limit (m_limit),
        .u_base  (u_base),
        .u_limit (u_limit)
    ) exec_pmp_i (
        .addr     (mem_addr),
        .cur_priv (cur_priv),
        .perm_x   (perm_x)
    );

endmodule

`default_nettype wire

/* test/fetch_assert.sv */
// Fetch stage bus and output checks
`timescale 1ns/10ps
`default_nettype none

module fetch_assert (
    input wire logic clk,
    input wire logic rst,
    input wire logic clear,
    input wire logic mem_re,
    input wire logic q_valid,
    input wire logic q_trap
);

    // No bus traffic in reset.
    no_req_in_reset: assert property (@(posedge clk) rst |-> !mem_re)
        else $error("mem_re high during reset");

    // Instruction or trap, never both.
    valid_trap_excl: assert property (@(posedge clk) !(q_valid && q_trap))
        else $error("q_valid and q_trap high together");

    // Clear kills the output.
    quiet_on_clear: assert property (@(posedge clk) clear |-> !(q_valid || q_trap))
        else $error("output while clear high");

endmodule

// Every fetch stage gets the checks.
bind fetch_stage fetch_assert fetch_assert_i (
    .clk     (clk),
    .rst     (rst),
    .clear   (clear),
    .mem_re  (mem_re),
    .q_valid (q_valid),
    .q_trap  (q_trap)
);

`default_nettype wire

/* test/fetch_tb.sv */
// Fetch stage testbench
`timescale 1ns/10ps
`default_nettype none

module fetch_tb import fetch_pkg::*; ();

    // DUT configuration.
    localparam logic [31:0] entrypoint = 32'h0000_0100;
    localparam int          buf_depth  = 4;
    localparam logic [31:0] m_base     = 32'h0000_0000;
    localparam logic [31:0] m_limit    = 32'h0000_0800;
    localparam logic [31:0] u_base     = 32'h0000_0400;
    localparam logic [31:0] u_limit    = 32'h0000_1000;

    // Run length in checked outputs, and the cycle limit.
    localparam int n_outputs      = 3000;
    localparam int timeout_cycles = 20 * n_outputs;
    // Halfwords in the program image, 8 KiB wrapping.
    localparam int img_hw         = 4096;
    // Redirect-free cycles right after reset.
    localparam int quiet_cycles   = 24;

    logic   clk = 1'b0;
    logic   rst;
    logic   clear;
    logic   fence_i;
    priv_t  cur_priv;
    logic   stall;
    logic   exception;
    pc_t    tvec;
    logic   branch_correct;
    pc_t    branch_alt;
    logic   branch_predict;
    pc_t    branch_target;
    pc_t    next_pc;
    logic   mem_re;
    waddr_t mem_addr;
    word_t  mem_rdata;
    logic   mem_ready;
    logic   q_valid;
    pc_t    q_pc;
    word_t  q_insn;
    logic   q_trap;
    cause_t q_cause;

    // Program image, one entry per halfword.
    logic [15:0] img [img_hw];
    integer      seed;
    // Request of the previous cycle, answered in this one.
    logic        req_re;
    waddr_t      req_addr;
    // Reference PC.
    pc_t         exp_pc;
    int          cycles = 0;
    int          n_checked;
    int          n_trap;
    int          n_long;

    fetch_top #(
        .entrypoint (entrypoint),
        .buf_depth  (buf_depth),
        .m_base     (m_base),
        .m_limit    (m_limit),
        .u_base     (u_base),
        .u_limit    (u_limit)
    ) fetch_top_i (
        .clk            (clk),
        .rst            (rst),
        .clear          (clear),
        .fence_i        (fence_i),
        .cur_priv       (cur_priv),
        .stall          (stall),
        .exception      (exception),
        .tvec           (tvec),
        .branch_correct (branch_correct),
        .branch_alt     (branch_alt),
        .branch_predict (branch_predict),
        .branch_target  (branch_target),
        .next_pc        (next_pc),
        .mem_re         (mem_re),
        .mem_addr       (mem_addr),
        .mem_rdata      (mem_rdata),
        .mem_ready      (mem_ready),
        .q_valid        (q_valid),
        .q_pc           (q_pc),
        .q_insn         (q_insn),
        .q_trap         (q_trap),
        .q_cause        (q_cause)
    );

    // 8 ns clock.
    always #4 clk = ~clk;

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("TEST FAIL");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_pc(input string name, input pc_t got, input pc_t exp);
        if (got !== exp) begin
            fail_run($sformatf("error at %0t: %s got %h expected %h", $time, name, got, exp));
        end
    endtask

    task automatic check_insn(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            fail_run($sformatf("error at %0t: %s got %h expected %h", $time, name, got, exp));
        end
    endtask

    task automatic check_cause(input string name, input cause_t got, input cause_t exp);
        if (got !== exp) begin
            fail_run($sformatf("error at %0t: %s got %h expected %h", $time, name, got, exp));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            fail_run($sformatf("error at %0t: %s got %b expected %b", $time, name, got, exp));
        end
    endtask

    // Image wraps at 8 KiB.
    function automatic logic [15:0] hw_at(input pc_t a);
        return img[a[12:1]];
    endfunction

    function automatic word_t word_at(input waddr_t w);
        return {img[{w[12:2], 1'b1}], img[{w[12:2], 1'b0}]};
    endfunction

    // Execute rule per privilege, limits exclusive.
    function automatic logic exec_allowed(input pc_t a, input priv_t p);
        logic [31:0] b;
        b = {a[31:2], 2'b00};
        if (p == priv_machine) begin
            return b >= m_base && b < m_limit;
        end
        return b >= u_base && b < u_limit;
    endfunction

    task automatic fill_image();
        logic [31:0] r;
        logic [15:0] hw;
        for (int i = 0; i < img_hw; i++) begin
            r  = $random(seed);
            hw = r[15:0];
            // About half the slots open a 32-bit instruction.
            if (r[16]) begin
                hw[1:0] = 2'b11;
            end else if (hw[1:0] == 2'b11) begin
                hw[1:0] = 2'b01;
            end
            img[i] = hw;
        end
    endtask

    // Memory answer plus one cycle of redirect stimulus.
    task automatic drive_cycle(input logic quiet);
        logic [31:0] r;
        logic [31:0] d;
        logic [31:0] t;
        r = $random(seed);
        d = $random(seed);
        // Drop about 1 in 8 answers.
        mem_ready = req_re && r[26:24] != 3'd0;
        mem_rdata = mem_ready ? word_at(req_addr) : d;
        stall          = !quiet && r[2:0] == 3'd0;
        exception      = !quiet && r[7:3] == 5'd0;
        branch_correct = !quiet && r[11:8] == 4'd0;
        branch_predict = !quiet && r[14:12] == 3'd0;
        clear          = !quiet && r[18:15] == 4'd0;
        fence_i        = !quiet && r[23:19] == 5'd0;
        // Privilege only changes together with a fence.
        if (fence_i && r[27]) begin
            cur_priv = cur_priv == priv_machine ? priv_user : priv_machine;
        end
        t = $random(seed);
        tvec = pc_t'(t[12:1]);
        t = $random(seed);
        branch_alt = pc_t'(t[12:1]);
        t = $random(seed);
        branch_target = pc_t'(t[12:1]);
    endtask

    // Reference model, one call per cycle with inputs settled.
    task automatic check_outputs();
        pc_t         fa;
        logic [15:0] lo;
        logic [15:0] hi;
        logic        long_insn;
        logic        fired;
        logic        denied;
        word_t       exp_insn;
        word_t       got_insn;
        cause_t      exp_cause;
        // Registered PC of the stage.
        check_pc("next_pc", next_pc, exp_pc);
        if (stall) begin
            fa = exp_pc;
        end else if (exception) begin
            fa = {tvec[31:2], 1'b0};
        end else if (branch_correct) begin
            fa = branch_alt;
        end else if (branch_predict) begin
            fa = branch_target;
        end else begin
            fa = exp_pc;
        end
        lo        = hw_at(fa);
        hi        = hw_at(fa + pc_t'(1));
        long_insn = lo[1:0] == 2'b11;
        fired     = q_valid || q_trap;
        denied    = !exec_allowed(fa, cur_priv)
                    || (long_insn && !exec_allowed(fa + pc_t'(1), cur_priv));
        if (q_valid && q_trap) begin
            fail_run("q_valid and q_trap were high in the same cycle");
        end
        if (fired && (clear || fence_i)) begin
            fail_run("an output appeared while clear or fence_i was high");
        end
        if (fired) begin
            // First output comes from the reset PC.
            if (n_checked == 0) begin
                check_pc("q_pc", q_pc, pc_t'(entrypoint[31:1]));
            end
            check_pc("q_pc", q_pc, fa);
            check_flag("q_trap", q_trap, denied);
            // Upper half only counts for 32-bit instructions.
            exp_insn  = long_insn ? {hi, lo} : {16'h0000, lo};
            got_insn  = long_insn ? q_insn : {16'h0000, q_insn[15:0]};
            check_insn("q_insn", got_insn, exp_insn);
            exp_cause = denied ? cause_iaccess : cause_t'(0);
            check_cause("q_cause", q_cause, exp_cause);
            n_checked++;
            n_trap += denied ? 1 : 0;
            n_long += long_insn ? 1 : 0;
        end
        if (!stall) begin
            if (!fired) begin
                exp_pc = fa;
            end else if (long_insn) begin
                exp_pc = fa + pc_t'(2);
            end else begin
                exp_pc = fa + pc_t'(1);
            end
        end
    endtask

    // Watchdog.
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= timeout_cycles) begin
            fail_run($sformatf("timeout after %0d cycles, %0d of %0d outputs checked",
                               cycles, n_checked, n_outputs));
        end
    end

    initial begin
        int cyc;
        seed           = 32'hd9bd7afc;
        rst            = 1'b1;
        clear          = 1'b0;
        fence_i        = 1'b0;
        cur_priv       = priv_machine;
        stall          = 1'b0;
        exception      = 1'b0;
        tvec           = '0;
        branch_correct = 1'b0;
        branch_alt     = '0;
        branch_predict = 1'b0;
        branch_target  = '0;
        mem_rdata      = '0;
        mem_ready      = 1'b0;
        req_re         = 1'b0;
        req_addr       = '0;
        exp_pc         = entrypoint[31:1];
        n_checked      = 0;
        n_trap         = 0;
        n_long         = 0;
        cyc            = 0;
        fill_image();
        // Reset, bus and outputs must stay quiet.
        repeat (7) begin
            @(negedge clk);
            #2;
            if (mem_re || q_valid || q_trap) begin
                fail_run("bus request or output seen during reset");
            end
        end
        @(negedge clk);
        rst = 1'b0;
        while (n_checked < n_outputs) begin
            drive_cycle(cyc < quiet_cycles);
            #2;
            check_outputs();
            req_re   = mem_re;
            req_addr = mem_addr;
            cyc++;
            @(negedge clk);
        end
        if (n_trap == 0 || n_long == 0 || n_trap == n_checked) begin
            fail_run("run ended without traps, 32-bit instructions or valid outputs");
        end else begin
            $display("TEST PASS");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* files.f */
hdl/fetch_pkg.sv
hdl/onehot_mux.sv
hdl/fetch_buffer_lookup.sv
hdl/fetch_stage.sv
hdl/exec_pmp.sv
hdl/fetch_top.sv
test/fetch_assert.sv
test/fetch_tb.sv

/* Makefile */
# Verilator build and run for the fetch stage testbench.

VERILATOR ?= verilator
TOP       ?= fetch_tb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only -Wall --timing --assert
FAIL_MSG  ?= TEST FAIL
PASS_MSG  ?= TEST PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

# The log decides the result.
run: build
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "Simulation stopped early, see $(LOG)"; exit 1; }

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
